/* Bender.yml */
package:
  name: io_system

sources:
  - source/io_pkg.sv
  - source/irq_controller.sv
  - source/io_timer.sv
  - source/watchdog.sv
  - source/gpio_port.sv
  - source/io_system.sv
  - target: test
    files:
      - verif/tb_io_system.sv

/* source/gpio_port.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_port (
	input  logic clk,
	input  logic rst,
	inout  tri logic [io_pkg::BYTE_W-1:0] pins,
	input  logic [io_pkg::BYTE_W-1:0] data_in,
	input  logic ddr_write,
	input  logic odr_write,
	input  logic pr_write,
	output logic [io_pkg::BYTE_W-1:0] ddr_out, // 1 drives the pin.
	output logic [io_pkg::BYTE_W-1:0] odr_out,
	output logic [io_pkg::BYTE_W-1:0] idr_out,
	output logic [io_pkg::BYTE_W-1:0] pr_out // Input polarity.
);
	import io_pkg::*;

	logic [BYTE_W-1:0] pin_meta; // First sync stage.
	logic [BYTE_W-1:0] pin_sync;

	// Per-bit tri-state buffers.
	for (genvar i = 0; i < BYTE_W; i++)
	begin : g_pin
		assign pins[i] = ddr_out[i] ? odr_out[i] : 1'bz;
	end

	always_ff @(posedge clk)
	begin
		pin_meta <= pins;
		pin_sync <= pin_meta;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ddr_out <= '0;
			odr_out <= '0;
			pr_out <= '0;
		end
		else
		begin
			if (ddr_write)
				ddr_out <= data_in;
			if (odr_write)
				odr_out <= data_in;
			if (pr_write)
				pr_out <= data_in;
		end
	end

	assign idr_out = pin_sync ^ pr_out; // Synchronized pins with polarity applied.

endmodule

`default_nettype wire

/* source/io_pkg.sv */
`default_nettype none

package io_pkg;

	// Bus widths.
	localparam int BYTE_W = 8;
	localparam int ADDR_W = 15; // Word address, byte address / 2.
	localparam int REG16_W = 16;

	localparam int NUM_IRQ = 2; // Bit 0 overflow, bit 1 compare.
	localparam int WDT_RESET_LEN = 4; // Cycles of sys_reset.

	// Byte offsets, timer and watchdog.
	localparam int unsigned OFS_CFG = 0;
	localparam int unsigned OFS_CNT = 2;
	localparam int unsigned OFS_RLD = 4;
	localparam int unsigned OFS_CMP = 6;
	// Byte offsets, GPIO.
	localparam int unsigned OFS_DDR = 0;
	localparam int unsigned OFS_ODR = 2;
	localparam int unsigned OFS_IDR = 4;
	localparam int unsigned OFS_PR = 6;
	// Byte offsets, interrupt controller.
	localparam int unsigned OFS_IEN = 0;
	localparam int unsigned OFS_IACT = 2;

	typedef enum logic {SRC_CLK = 1'b0, SRC_EXT = 1'b1} timer_src_e; // Timer cfg bit 2.
	typedef enum logic [1:0] {CAUSE_NONE = 2'd0, CAUSE_WDT = 2'd1, CAUSE_TRAP = 2'd2} reset_cause_e;

	// Byte-lane update of a 16-bit register, bit 0 low byte, bit 1 high byte.
	function automatic logic [REG16_W-1:0] lane_merge(input logic [REG16_W-1:0] cur,
		input logic [REG16_W-1:0] data, input logic [1:0] we);
		lane_merge = cur;
		if (we[0])
			lane_merge[BYTE_W-1:0] = data[BYTE_W-1:0];
		if (we[1])
			lane_merge[REG16_W-1:BYTE_W] = data[REG16_W-1:BYTE_W];
	endfunction

endpackage

`default_nettype wire

/* source/io_system.sv */
`timescale 1ns/1ps
`default_nettype none

module io_system #(
	parameter logic [15:0] IRQ_BASE = 16'h0010,
	parameter logic [15:0] TIMER_BASE = 16'h0018,
	parameter logic [15:0] WDT_BASE = 16'h0020,
	parameter logic [15:0] GPIO0_BASE = 16'h0028,
	parameter logic [15:0] GPIO1_BASE = 16'h0030
) (
	input  logic clk,
	input  logic rst,
	input  logic [io_pkg::ADDR_W-1:0] read_addr_even,
	output logic [io_pkg::BYTE_W-1:0] read_data_even,
	input  logic [io_pkg::ADDR_W-1:0] write_addr_even,
	input  logic [io_pkg::BYTE_W-1:0] write_data_even,
	input  logic write_en_even,
	input  logic [io_pkg::ADDR_W-1:0] read_addr_odd,
	output logic [io_pkg::BYTE_W-1:0] read_data_odd,
	input  logic [io_pkg::ADDR_W-1:0] write_addr_odd,
	input  logic [io_pkg::BYTE_W-1:0] write_data_odd,
	input  logic write_en_odd,
	output logic interrupt,
	output logic sys_reset,
	input  logic trap,
	input  logic timer_in,
	inout  tri logic [io_pkg::BYTE_W-1:0] gpio0_pins,
	inout  tri logic [io_pkg::BYTE_W-1:0] gpio1_pins
);
	import io_pkg::*;

	// Word addresses; high bytes share the word of their low byte.
	localparam logic [ADDR_W-1:0] WA_IEN = ADDR_W'((IRQ_BASE + OFS_IEN) >> 1);
	localparam logic [ADDR_W-1:0] WA_IACT = ADDR_W'((IRQ_BASE + OFS_IACT) >> 1);
	localparam logic [ADDR_W-1:0] WA_TCFG = ADDR_W'((TIMER_BASE + OFS_CFG) >> 1);
	localparam logic [ADDR_W-1:0] WA_TCNT = ADDR_W'((TIMER_BASE + OFS_CNT) >> 1);
	localparam logic [ADDR_W-1:0] WA_TRLD = ADDR_W'((TIMER_BASE + OFS_RLD) >> 1);
	localparam logic [ADDR_W-1:0] WA_TCMP = ADDR_W'((TIMER_BASE + OFS_CMP) >> 1);
	localparam logic [ADDR_W-1:0] WA_WCFG = ADDR_W'((WDT_BASE + OFS_CFG) >> 1);
	localparam logic [ADDR_W-1:0] WA_WCNT = ADDR_W'((WDT_BASE + OFS_CNT) >> 1);
	localparam logic [ADDR_W-1:0] WA_WRLD = ADDR_W'((WDT_BASE + OFS_RLD) >> 1);
	localparam logic [ADDR_W-1:0] WA_G0DDR = ADDR_W'((GPIO0_BASE + OFS_DDR) >> 1);
	localparam logic [ADDR_W-1:0] WA_G0ODR = ADDR_W'((GPIO0_BASE + OFS_ODR) >> 1);
	localparam logic [ADDR_W-1:0] WA_G0IDR = ADDR_W'((GPIO0_BASE + OFS_IDR) >> 1);
	localparam logic [ADDR_W-1:0] WA_G0PR = ADDR_W'((GPIO0_BASE + OFS_PR) >> 1);
	localparam logic [ADDR_W-1:0] WA_G1DDR = ADDR_W'((GPIO1_BASE + OFS_DDR) >> 1);
	localparam logic [ADDR_W-1:0] WA_G1ODR = ADDR_W'((GPIO1_BASE + OFS_ODR) >> 1);
	localparam logic [ADDR_W-1:0] WA_G1IDR = ADDR_W'((GPIO1_BASE + OFS_IDR) >> 1);
	localparam logic [ADDR_W-1:0] WA_G1PR = ADDR_W'((GPIO1_BASE + OFS_PR) >> 1);

	logic wr_ien, wr_iact, wr_kick; // Even-lane strobes.
	logic wr_tcfg, wr_wcfg;
	logic wr_g0_ddr, wr_g0_odr, wr_g0_pr;
	logic wr_g1_ddr, wr_g1_odr, wr_g1_pr;
	logic [1:0] wr_tcnt, wr_trld, wr_tcmp; // {odd, even}.
	logic [1:0] wr_wcnt, wr_wrld;
	logic [REG16_W-1:0] wdata16; // Both lanes.
	logic [NUM_IRQ-1:0] irq_lines, irq_enable, irq_active;
	logic tmr_ovf_irq, tmr_cmp_irq;
	logic [REG16_W-1:0] tmr_cnt, tmr_rld, tmr_cmp, wdt_cnt, wdt_rld;
	logic [BYTE_W-1:0] tmr_cfg, wdt_cfg;
	logic [BYTE_W-1:0] g0_ddr, g0_odr, g0_idr, g0_pr;
	logic [BYTE_W-1:0] g1_ddr, g1_odr, g1_idr, g1_pr;
	logic [BYTE_W-1:0] mux_even, mux_odd; // Unregistered read data.

	assign wdata16 = {write_data_odd, write_data_even};
	assign irq_lines = {tmr_cmp_irq, tmr_ovf_irq};

	// Write decode.
	assign wr_ien = write_en_even && (write_addr_even == WA_IEN);
	assign wr_iact = write_en_even && (write_addr_even == WA_IACT);
	assign wr_kick = write_en_even && (write_addr_even == '0); // Word 0 kicks the watchdog.
	assign wr_tcfg = write_en_even && (write_addr_even == WA_TCFG);
	assign wr_wcfg = write_en_even && (write_addr_even == WA_WCFG);
	assign wr_g0_ddr = write_en_even && (write_addr_even == WA_G0DDR);
	assign wr_g0_odr = write_en_even && (write_addr_even == WA_G0ODR);
	assign wr_g0_pr = write_en_even && (write_addr_even == WA_G0PR);
	assign wr_g1_ddr = write_en_even && (write_addr_even == WA_G1DDR);
	assign wr_g1_odr = write_en_even && (write_addr_even == WA_G1ODR);
	assign wr_g1_pr = write_en_even && (write_addr_even == WA_G1PR);
	assign wr_tcnt = {write_en_odd && (write_addr_odd == WA_TCNT),
		write_en_even && (write_addr_even == WA_TCNT)};
	assign wr_trld = {write_en_odd && (write_addr_odd == WA_TRLD),
		write_en_even && (write_addr_even == WA_TRLD)};
	assign wr_tcmp = {write_en_odd && (write_addr_odd == WA_TCMP),
		write_en_even && (write_addr_even == WA_TCMP)};
	assign wr_wcnt = {write_en_odd && (write_addr_odd == WA_WCNT),
		write_en_even && (write_addr_even == WA_WCNT)};
	assign wr_wrld = {write_en_odd && (write_addr_odd == WA_WRLD),
		write_en_even && (write_addr_even == WA_WRLD)};

	// Even lane: low bytes and 8-bit registers.
	always_comb
	begin
		case (read_addr_even)
			WA_IEN: mux_even = BYTE_W'(irq_enable);
			WA_IACT: mux_even = BYTE_W'(irq_active);
			WA_TCFG: mux_even = tmr_cfg;
			WA_TCNT: mux_even = tmr_cnt[BYTE_W-1:0];
			WA_TRLD: mux_even = tmr_rld[BYTE_W-1:0];
			WA_TCMP: mux_even = tmr_cmp[BYTE_W-1:0];
			WA_WCFG: mux_even = wdt_cfg;
			WA_WCNT: mux_even = wdt_cnt[BYTE_W-1:0];
			WA_WRLD: mux_even = wdt_rld[BYTE_W-1:0];
			WA_G0DDR: mux_even = g0_ddr;
			WA_G0ODR: mux_even = g0_odr;
			WA_G0IDR: mux_even = g0_idr;
			WA_G0PR: mux_even = g0_pr;
			WA_G1DDR: mux_even = g1_ddr;
			WA_G1ODR: mux_even = g1_odr;
			WA_G1IDR: mux_even = g1_idr;
			WA_G1PR: mux_even = g1_pr;
			default: mux_even = '0; // Unmapped.
		endcase
	end

	// Odd lane: high bytes only.
	always_comb
	begin
		case (read_addr_odd)
			WA_TCNT: mux_odd = tmr_cnt[REG16_W-1:BYTE_W];
			WA_TRLD: mux_odd = tmr_rld[REG16_W-1:BYTE_W];
			WA_TCMP: mux_odd = tmr_cmp[REG16_W-1:BYTE_W];
			WA_WCNT: mux_odd = wdt_cnt[REG16_W-1:BYTE_W];
			WA_WRLD: mux_odd = wdt_rld[REG16_W-1:BYTE_W];
			default: mux_odd = '0;
		endcase
	end

	// One cycle read latency, same-lane write data bypasses the mux.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			read_data_even <= '0;
			read_data_odd <= '0;
		end
		else
		begin
			if (write_en_even && (write_addr_even == read_addr_even))
				read_data_even <= write_data_even;
			else
				read_data_even <= mux_even;
			if (write_en_odd && (write_addr_odd == read_addr_odd))
				read_data_odd <= write_data_odd;
			else
				read_data_odd <= mux_odd;
		end
	end

	irq_controller #(.NUM_INPUTS(NUM_IRQ)) u_irq (.clk(clk), .rst(rst), .irq_in(irq_lines),
		.enable_in(write_data_even[NUM_IRQ-1:0]), .enable_write(wr_ien),
		.clear_in(write_data_even[NUM_IRQ-1:0]), .clear_write(wr_iact),
		.enable_out(irq_enable), .active_out(irq_active), .interrupt(interrupt));

	io_timer u_timer (.clk(clk), .rst(rst), .timer_in(timer_in), .data_in(wdata16),
		.cfg_in(write_data_even), .counter_write(wr_tcnt), .reload_write(wr_trld),
		.compare_write(wr_tcmp), .cfg_write(wr_tcfg), .counter_out(tmr_cnt),
		.reload_out(tmr_rld), .compare_out(tmr_cmp), .cfg_out(tmr_cfg),
		.overflow_irq(tmr_ovf_irq), .compare_irq(tmr_cmp_irq));

	watchdog u_wdt (.clk(clk), .rst(rst), .trap(trap), .kick(wr_kick), .data_in(wdata16),
		.cfg_in(write_data_even), .counter_write(wr_wcnt), .reload_write(wr_wrld),
		.cfg_write(wr_wcfg), .counter_out(wdt_cnt), .reload_out(wdt_rld), .cfg_out(wdt_cfg),
		.sys_reset(sys_reset));

	gpio_port u_gpio0 (.clk(clk), .rst(rst), .pins(gpio0_pins), .data_in(write_data_even),
		.ddr_write(wr_g0_ddr), .odr_write(wr_g0_odr), .pr_write(wr_g0_pr),
		.ddr_out(g0_ddr), .odr_out(g0_odr), .idr_out(g0_idr), .pr_out(g0_pr));

	gpio_port u_gpio1 (.clk(clk), .rst(rst), .pins(gpio1_pins), .data_in(write_data_even),
		.ddr_write(wr_g1_ddr), .odr_write(wr_g1_odr), .pr_write(wr_g1_pr),
		.ddr_out(g1_ddr), .odr_out(g1_odr), .idr_out(g1_idr), .pr_out(g1_pr));

endmodule

`default_nettype wire

/* source/io_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module io_timer (
	input  logic clk,
	input  logic rst,
	input  logic timer_in, // External count source, asynchronous.
	input  logic [io_pkg::REG16_W-1:0] data_in, // {odd, even} write data.
	input  logic [io_pkg::BYTE_W-1:0] cfg_in,
	input  logic [1:0] counter_write, // Bit 0 low byte, bit 1 high byte.
	input  logic [1:0] reload_write,
	input  logic [1:0] compare_write,
	input  logic cfg_write,
	output logic [io_pkg::REG16_W-1:0] counter_out,
	output logic [io_pkg::REG16_W-1:0] reload_out,
	output logic [io_pkg::REG16_W-1:0] compare_out,
	output logic [io_pkg::BYTE_W-1:0] cfg_out,
	output logic overflow_irq,
	output logic compare_irq
);
	import io_pkg::*;

	logic [1:0] in_sync; // Two-flop synchronizer.
	logic in_prev; // Edge flop.
	logic ext_edge;
	timer_src_e src;
	logic tick; // Count this cycle.
	logic wrap;
	logic [REG16_W-1:0] count_val;

	assign ext_edge = in_sync[1] && !in_prev; // Rising edge of timer_in.
	assign src = timer_src_e'(cfg_out[2]);
	assign tick = cfg_out[0] && ((src == SRC_CLK) || ext_edge);
	assign wrap = (counter_out == '1);
	assign count_val = wrap ? reload_out : counter_out + 1'b1; // Reload on overflow.

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			in_sync <= '0;
			in_prev <= 1'b0;
		end
		else
		begin
			in_sync <= {in_sync[0], timer_in};
			in_prev <= in_sync[1];
		end
	end

	// Config, reload and compare registers.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cfg_out <= '0;
			reload_out <= '0;
			compare_out <= '0;
		end
		else
		begin
			if (cfg_write)
				cfg_out <= cfg_in;
			reload_out <= lane_merge(reload_out, data_in, reload_write);
			compare_out <= lane_merge(compare_out, data_in, compare_write);
		end
	end

	// Counter and interrupt pulses.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			counter_out <= '0;
			overflow_irq <= 1'b0;
			compare_irq <= 1'b0;
		end
		else
		begin
			overflow_irq <= 1'b0;
			compare_irq <= 1'b0;
			if (|counter_write)
				counter_out <= lane_merge(counter_out, data_in, counter_write); // Bus write wins.
			else if (tick)
			begin
				counter_out <= count_val;
				overflow_irq <= wrap;
				compare_irq <= (count_val == compare_out); // Equal after this count.
			end
		end
	end

endmodule

`default_nettype wire

/* source/irq_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module irq_controller #(
	parameter int NUM_INPUTS = io_pkg::NUM_IRQ
) (
	input  logic clk,
	input  logic rst,
	input  logic [NUM_INPUTS-1:0] irq_in, // Single-cycle pulses.
	input  logic [NUM_INPUTS-1:0] enable_in,
	input  logic enable_write,
	input  logic [NUM_INPUTS-1:0] clear_in, // Write 1 to clear.
	input  logic clear_write,
	output logic [NUM_INPUTS-1:0] enable_out,
	output logic [NUM_INPUTS-1:0] active_out,
	output logic interrupt
);

	logic [NUM_INPUTS-1:0] clear_mask;

	// Clear only on an actual write.
	assign clear_mask = clear_write ? clear_in : '0;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			enable_out <= '0;
			active_out <= '0;
			interrupt <= 1'b0;
		end
		else
		begin
			if (enable_write)
				enable_out <= enable_in;
			// New pulse wins over a clear.
			active_out <= (active_out & ~clear_mask) | irq_in;
			// Registered, one cycle after active.
			interrupt <= |(active_out & enable_out);
		end
	end

endmodule

`default_nettype wire

/* source/watchdog.sv */
`timescale 1ns/1ps
`default_nettype none

module watchdog (
	input  logic clk,
	input  logic rst,
	input  logic trap, // Pulse from the processor.
	input  logic kick, // Reloads the counter.
	input  logic [io_pkg::REG16_W-1:0] data_in,
	input  logic [io_pkg::BYTE_W-1:0] cfg_in,
	input  logic [1:0] counter_write,
	input  logic [1:0] reload_write,
	input  logic cfg_write,
	output logic [io_pkg::REG16_W-1:0] counter_out,
	output logic [io_pkg::REG16_W-1:0] reload_out,
	output logic [io_pkg::BYTE_W-1:0] cfg_out,
	output logic sys_reset
);
	import io_pkg::*;

	localparam int LEN_W = $clog2(WDT_RESET_LEN + 1);

	logic [LEN_W-1:0] hold_cnt; // Remaining sys_reset cycles.
	logic [BYTE_W-3:0] cfg_bits; // Writable part, bit 0 enable.
	reset_cause_e cause;
	logic expire;
	logic reset_event;

	assign expire = cfg_bits[0] && (counter_out == '0);
	assign reset_event = expire || trap; // Trap ignores the enable.
	assign cfg_out = {cause, cfg_bits}; // Cause in bits 7:6.
	assign sys_reset = (hold_cnt != '0);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			counter_out <= '0;
			reload_out <= '0;
			cfg_bits <= '0;
			cause <= CAUSE_NONE;
			hold_cnt <= '0;
		end
		else
		begin
			reload_out <= lane_merge(reload_out, data_in, reload_write);
			if (cfg_write)
				cfg_bits <= cfg_in[BYTE_W-3:0];
			if (reset_event)
			begin
				cause <= trap ? CAUSE_TRAP : CAUSE_WDT;
				cfg_bits[0] <= 1'b0; // Overrides a same-cycle cfg write.
				hold_cnt <= LEN_W'(WDT_RESET_LEN);
				counter_out <= reload_out;
			end
			else
			begin
				if (hold_cnt != '0)
					hold_cnt <= hold_cnt - 1'b1;
				if (|counter_write)
					counter_out <= lane_merge(counter_out, data_in, counter_write);
				else if (kick)
					counter_out <= reload_out;
				else if (cfg_bits[0])
					counter_out <= counter_out - 1'b1; // Nonzero here.
			end
		end
	end

endmodule

`default_nettype wire

/* sources.f */
source/io_pkg.sv
source/irq_controller.sv
source/io_timer.sv
source/watchdog.sv
source/gpio_port.sv
source/io_system.sv
verif/tb_io_system.sv

/* verif/tb_io_system.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_io_system;
	import io_pkg::*;

	localparam logic [15:0] IRQ_BASE = 16'h0010;
	localparam logic [15:0] TIMER_BASE = 16'h0018;
	localparam logic [15:0] WDT_BASE = 16'h0020;
	localparam logic [15:0] GPIO0_BASE = 16'h0028;
	localparam logic [15:0] GPIO1_BASE = 16'h0030;
	localparam int TIMEOUT = 50; // Cycles per wait loop.

	// Word addresses, byte address / 2.
	localparam logic [ADDR_W-1:0] A_IEN = ADDR_W'((IRQ_BASE + OFS_IEN) >> 1);
	localparam logic [ADDR_W-1:0] A_IACT = ADDR_W'((IRQ_BASE + OFS_IACT) >> 1);
	localparam logic [ADDR_W-1:0] A_TCFG = ADDR_W'((TIMER_BASE + OFS_CFG) >> 1);
	localparam logic [ADDR_W-1:0] A_TCNT = ADDR_W'((TIMER_BASE + OFS_CNT) >> 1);
	localparam logic [ADDR_W-1:0] A_TRLD = ADDR_W'((TIMER_BASE + OFS_RLD) >> 1);
	localparam logic [ADDR_W-1:0] A_TCMP = ADDR_W'((TIMER_BASE + OFS_CMP) >> 1);
	localparam logic [ADDR_W-1:0] A_WCFG = ADDR_W'((WDT_BASE + OFS_CFG) >> 1);
	localparam logic [ADDR_W-1:0] A_WCNT = ADDR_W'((WDT_BASE + OFS_CNT) >> 1);
	localparam logic [ADDR_W-1:0] A_WRLD = ADDR_W'((WDT_BASE + OFS_RLD) >> 1);
	localparam logic [ADDR_W-1:0] A_G0IDR = ADDR_W'((GPIO0_BASE + OFS_IDR) >> 1);
	localparam logic [ADDR_W-1:0] A_KICK = '0;
	localparam logic [ADDR_W-1:0] A_NONE = 15'h7FFF; // Unmapped, idle read address.

	logic clk, rst, write_en_even, write_en_odd, interrupt, sys_reset, trap, timer_in;
	logic [ADDR_W-1:0] read_addr_even, write_addr_even, read_addr_odd, write_addr_odd;
	logic [BYTE_W-1:0] read_data_even, write_data_even, read_data_odd, write_data_odd;
	tri [BYTE_W-1:0] gpio0_pins, gpio1_pins;
	logic [BYTE_W-1:0] pin_en [2]; // Testbench drives where DDR is 0.
	logic [BYTE_W-1:0] pin_val [2];
	integer seed = 32'hbe24_b853;
	int error_count = 0;

	// Pin models, one tri-state driver per bit.
	for (genvar i = 0; i < BYTE_W; i++)
	begin : g_pin_model
		assign gpio0_pins[i] = pin_en[0][i] ? pin_val[0][i] : 1'bz;
		assign gpio1_pins[i] = pin_en[1][i] ? pin_val[1][i] : 1'bz;
	end

	io_system #(.IRQ_BASE(IRQ_BASE), .TIMER_BASE(TIMER_BASE), .WDT_BASE(WDT_BASE),
		.GPIO0_BASE(GPIO0_BASE), .GPIO1_BASE(GPIO1_BASE)) u_dut (.clk(clk), .rst(rst),
		.read_addr_even(read_addr_even), .read_data_even(read_data_even),
		.write_addr_even(write_addr_even), .write_data_even(write_data_even),
		.write_en_even(write_en_even), .read_addr_odd(read_addr_odd),
		.read_data_odd(read_data_odd), .write_addr_odd(write_addr_odd),
		.write_data_odd(write_data_odd), .write_en_odd(write_en_odd), .interrupt(interrupt),
		.sys_reset(sys_reset), .trap(trap), .timer_in(timer_in), .gpio0_pins(gpio0_pins),
		.gpio1_pins(gpio1_pins));

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period.
	end

	task automatic next_cycle;
		@(posedge clk);
		#1; // Inputs move 1 ns after the edge.
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		$display("Error: %s expected 0x%0h actual 0x%0h", name, exp, act);
		error_count++;
	endtask

	task automatic report_failure(input string name, input string what);
		$display("%s: %s", name, what);
		error_count++;
	endtask

	// One bus cycle, writes on the lanes in mask, reads both lanes.
	task automatic bus_cycle(input logic [1:0] lanes, input logic [ADDR_W-1:0] waddr,
		input logic [15:0] wdata, input logic [ADDR_W-1:0] raddr, output logic [15:0] rdata);
		write_addr_even = waddr;
		write_addr_odd = waddr;
		{write_data_odd, write_data_even} = wdata;
		{write_en_odd, write_en_even} = lanes;
		read_addr_even = raddr;
		read_addr_odd = raddr;
		next_cycle;
		rdata = {read_data_odd, read_data_even}; // Registered, stable after the edge.
		{write_en_odd, write_en_even} = 2'b00;
	endtask

	task automatic bus_write(input logic [1:0] lanes, input logic [ADDR_W-1:0] addr,
		input logic [15:0] data);
		logic [15:0] unused;
		bus_cycle(lanes, addr, data, A_NONE, unused);
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [15:0] data);
		bus_cycle(2'b00, A_NONE, 16'h0000, addr, data);
	endtask

	// Even-lane register; odd lane must read zero.
	task automatic check_reg8_access(input logic [ADDR_W-1:0] addr, input logic [7:0] wmask,
		input logic [7:0] rmask);
		logic [7:0] val;
		logic [15:0] rd;
		val = 8'($random(seed)) & wmask;
		bus_write(2'b01, addr, {8'h00, val});
		bus_read(addr, rd);
		if (rd !== {8'h00, val & rmask})
			report_mismatch("register_access 8-bit", {8'h00, val & rmask}, rd);
	endtask

	task automatic check_reg16_access(input logic [ADDR_W-1:0] addr);
		logic [15:0] val, rd;
		val = 16'($random(seed));
		bus_write(2'b01, addr, {8'h00, val[7:0]}); // Low byte alone.
		bus_write(2'b10, addr, {val[15:8], 8'h00});
		bus_read(addr, rd);
		if (rd !== val)
			report_mismatch("register_access by lane", val, rd);
		val = 16'($random(seed));
		bus_write(2'b11, addr, val); // Atomic.
		bus_read(addr, rd);
		if (rd !== val)
			report_mismatch("register_access atomic", val, rd);
	endtask

	task automatic test_register_access;
		logic [ADDR_W-1:0] holes [6];
		logic [15:0] val, rd;
		check_reg8_access(A_IEN, 8'hFF, 8'h03); // Only NUM_IRQ bits exist.
		check_reg8_access(A_TCFG, 8'hFE, 8'hFF); // Timer kept stopped.
		check_reg8_access(A_WCFG, 8'hFE, 8'h3F); // Cause bits read-only, still none.
		for (int p = 0; p < 2; p++)
		begin
			check_reg8_access(ADDR_W'(((p == 0 ? GPIO0_BASE : GPIO1_BASE) + OFS_DDR) >> 1),
				8'hFF, 8'hFF);
			check_reg8_access(ADDR_W'(((p == 0 ? GPIO0_BASE : GPIO1_BASE) + OFS_ODR) >> 1),
				8'hFF, 8'hFF);
			check_reg8_access(ADDR_W'(((p == 0 ? GPIO0_BASE : GPIO1_BASE) + OFS_PR) >> 1),
				8'hFF, 8'hFF);
		end
		check_reg16_access(A_TCNT);
		check_reg16_access(A_TRLD);
		check_reg16_access(A_TCMP);
		check_reg16_access(A_WCNT);
		check_reg16_access(A_WRLD);
		holes[0] = 15'h0000;
		holes[1] = 15'h0007;
		holes[2] = 15'h000B;
		holes[3] = 15'h0013;
		holes[4] = 15'h001C;
		holes[5] = 15'h4000 | 15'($random(seed)); // Far above the map.
		for (int i = 0; i < 6; i++)
		begin
			bus_read(holes[i], rd);
			if (rd !== 16'h0000)
				report_mismatch("register_access unmapped", 16'h0000, rd);
		end
		val = 16'($random(seed));
		bus_cycle(2'b11, A_TRLD, val, A_TRLD, rd); // Bypass.
		if (rd !== val)
			report_mismatch("register_access bypass", val, rd);
		bus_cycle(2'b01, A_G0IDR, val, A_G0IDR, rd); // Bypass on a read-only register.
		if (rd !== {8'h00, val[7:0]})
			report_mismatch("register_access bypass idr", {8'h00, val[7:0]}, rd);
	endtask

	task automatic check_gpio_port(input int port);
		logic [15:0] base, rd;
		logic [7:0] ddr, odr, pr, drive, exp_pins;
		int cycles;
		base = (port == 0) ? GPIO0_BASE : GPIO1_BASE;
		ddr = 8'($random(seed));
		odr = 8'($random(seed));
		pr = 8'($random(seed));
		drive = 8'($random(seed));
		pin_en[port] = 8'h00; // Release before DDR moves.
		bus_write(2'b01, ADDR_W'((base + OFS_ODR) >> 1), {8'h00, odr});
		bus_write(2'b01, ADDR_W'((base + OFS_PR) >> 1), {8'h00, pr});
		bus_write(2'b01, ADDR_W'((base + OFS_DDR) >> 1), {8'h00, ddr});
		pin_en[port] = ~ddr;
		pin_val[port] = drive;
		exp_pins = (odr & ddr) | (drive & ~ddr);
		next_cycle; // Pins settle before sampling.
		if (((port == 0) ? gpio0_pins : gpio1_pins) !== exp_pins)
			report_mismatch("gpio pins", {8'h00, exp_pins},
				{8'h00, (port == 0) ? gpio0_pins : gpio1_pins});
		cycles = 0;
		bus_read(ADDR_W'((base + OFS_IDR) >> 1), rd);
		while (rd !== {8'h00, exp_pins ^ pr} && cycles < TIMEOUT)
		begin
			bus_read(ADDR_W'((base + OFS_IDR) >> 1), rd);
			cycles++;
		end
		if (rd !== {8'h00, exp_pins ^ pr})
			report_mismatch("gpio idr", {8'h00, exp_pins ^ pr}, rd);
	endtask

	task automatic test_gpio;
		for (int r = 0; r < 4; r++)
			check_gpio_port(r % 2); // Two rounds per port.
	endtask

	task automatic test_timer_irq;
		logic [15:0] rd;
		int cycles;
		bus_write(2'b01, A_TCFG, 16'h0000);
		bus_write(2'b01, A_IACT, 16'h0003);
		bus_write(2'b11, A_TCNT, 16'hFFFD);
		bus_write(2'b11, A_TCMP, 16'hFFFE);
		bus_write(2'b11, A_TRLD, 16'h0100);
		bus_write(2'b01, A_IEN, 16'h0003);
		bus_write(2'b01, A_TCFG, {8'h00, 5'b00000, SRC_CLK, 2'b01});
		cycles = 0;
		while (interrupt !== 1'b1 && cycles < TIMEOUT)
		begin
			next_cycle;
			cycles++;
		end
		if (interrupt !== 1'b1)
			report_failure("timer_irq", "interrupt did not rise before the timeout");
		cycles = 0;
		rd = 16'h0000;
		while (rd[1:0] !== 2'b11 && cycles < TIMEOUT)
		begin
			bus_read(A_IACT, rd);
			cycles++;
		end
		if (rd !== 16'h0003)
			report_mismatch("timer_irq active", 16'h0003, rd);
		bus_write(2'b01, A_TCFG, 16'h0000); // Stop, next events are far away.
		bus_write(2'b01, A_IACT, 16'h0001);
		bus_read(A_IACT, rd);
		if (rd !== 16'h0002)
			report_mismatch("timer_irq clear bit 0", 16'h0002, rd);
		if (interrupt !== 1'b1)
			report_failure("timer_irq", "interrupt fell with compare still active");
		bus_write(2'b01, A_IACT, 16'h0003);
		cycles = 0;
		while (interrupt !== 1'b0 && cycles < TIMEOUT)
		begin
			next_cycle;
			cycles++;
		end
		if (interrupt !== 1'b0)
			report_failure("timer_irq", "interrupt stayed high after clearing both bits");
		// Masked overflow.
		bus_write(2'b01, A_IEN, 16'h0000);
		bus_write(2'b11, A_TCNT, 16'hFFFE);
		bus_write(2'b01, A_TCFG, {8'h00, 5'b00000, SRC_CLK, 2'b01});
		cycles = 0;
		rd = 16'h0000;
		while (rd[0] !== 1'b1 && cycles < TIMEOUT)
		begin
			bus_read(A_IACT, rd);
			cycles++;
		end
		if (rd !== 16'h0001)
			report_mismatch("timer_irq masked active", 16'h0001, rd);
		for (int i = 0; i < 3; i++)
		begin
			if (interrupt !== 1'b0)
				report_failure("timer_irq", "interrupt rose with the enables at 0");
			next_cycle;
		end
		bus_write(2'b01, A_TCFG, 16'h0000);
		bus_write(2'b01, A_IACT, 16'h0003);
	endtask

	task automatic test_ext_count;
		logic [15:0] rd;
		int n, hold;
		n = ({$random(seed)} % 20) + 1;
		bus_write(2'b01, A_TCFG, 16'h0000);
		bus_write(2'b11, A_TCNT, 16'h0000);
		bus_write(2'b01, A_TCFG, {8'h00, 5'b00000, SRC_EXT, 2'b01});
		for (int p = 0; p < n; p++)
		begin
			hold = 3 + ({$random(seed)} % 4);
			timer_in = 1'b1;
			repeat (hold) next_cycle;
			timer_in = 1'b0;
			repeat (hold) next_cycle;
		end
		repeat (4) next_cycle; // Synchronizer and edge flop drain.
		bus_write(2'b01, A_TCFG, 16'h0000);
		bus_read(A_TCNT, rd);
		if (rd !== 16'(n))
			report_mismatch("ext_count", 16'(n), rd);
	endtask

	// Waits for sys_reset and measures how long it stays high.
	task automatic measure_reset_pulse(input string name);
		int cycles, high_cycles;
		cycles = 0;
		while (sys_reset !== 1'b1 && cycles < TIMEOUT)
		begin
			next_cycle;
			cycles++;
		end
		if (sys_reset !== 1'b1)
			report_failure(name, "sys_reset did not rise before the timeout");
		else
		begin
			high_cycles = 0;
			while (sys_reset === 1'b1 && high_cycles < TIMEOUT)
			begin
				high_cycles++;
				next_cycle;
			end
			if (high_cycles != WDT_RESET_LEN)
				report_mismatch(name, 16'(WDT_RESET_LEN), 16'(high_cycles));
		end
	endtask

	task automatic test_watchdog;
		logic [15:0] rd;
		logic early;
		early = 1'b0;
		bus_write(2'b11, A_WRLD, 16'd20);
		bus_write(2'b01, A_KICK, 16'h0000); // Load 20.
		bus_write(2'b01, A_WCFG, 16'h0001);
		for (int i = 0; i < 200; i++)
		begin
			if (i % 10 == 0)
				bus_write(2'b01, A_KICK, 16'h0000);
			else
				next_cycle;
			if (sys_reset !== 1'b0)
				early = 1'b1;
		end
		if (early)
			report_failure("watchdog", "sys_reset rose while the watchdog was kicked");
		measure_reset_pulse("watchdog expiry pulse");
		bus_read(A_WCFG, rd);
		if (rd !== {8'h00, CAUSE_WDT, 6'b000000})
			report_mismatch("watchdog cause", {8'h00, CAUSE_WDT, 6'b000000}, rd);
		trap = 1'b1;
		next_cycle;
		trap = 1'b0;
		measure_reset_pulse("trap pulse");
		bus_read(A_WCFG, rd);
		if (rd !== {8'h00, CAUSE_TRAP, 6'b000000})
			report_mismatch("trap cause", {8'h00, CAUSE_TRAP, 6'b000000}, rd);
	endtask

	initial
	begin
		rst = 1'b1;
		trap = 1'b0;
		timer_in = 1'b0;
		read_addr_even = A_NONE;
		read_addr_odd = A_NONE;
		write_addr_even = A_NONE;
		write_addr_odd = A_NONE;
		write_data_even = '0;
		write_data_odd = '0;
		write_en_even = 1'b0;
		write_en_odd = 1'b0;
		pin_en[0] = '0;
		pin_en[1] = '0;
		pin_val[0] = '0;
		pin_val[1] = '0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		if (interrupt !== 1'b0 || sys_reset !== 1'b0)
			report_failure("reset", "interrupt or sys_reset not low after reset");
		test_register_access;
		test_gpio;
		test_timer_irq;
		test_ext_count;
		test_watchdog;
		$display("Errors: %0d", error_count);
		if (error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
